/* files.f */
design/pw_pkg.sv
design/pw_ctrl.sv
design/pw_operand_stage.sv
design/pw_alu.sv
design/pw_top.sv
verif/pw_tb_assert.sv
verif/pw_tb.sv

/* Bender.yml */
package:
  name: pw_engine

sources:
  - design/pw_pkg.sv
  - design/pw_ctrl.sv
  - design/pw_operand_stage.sv
  - design/pw_alu.sv
  - design/pw_top.sv
  - target: test
    files:
      - verif/pw_tb_assert.sv
      - verif/pw_tb.sv

/* verif/pw_tb.sv */
// ====================
// Pointwise engine testbench
// Models the A, B and C memories, runs a table of
// multiply, add and subtract commands with a zeroize abort
// and checks C against a modular reference model
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_tb;
    import pw_pkg::*;

    localparam int ROWS           = 8;
    localparam int RUN_CYCLES     = 68;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = ROWS * RUN_CYCLES + RESET_CYCLES + 200;
    localparam int SEED           = 28;

    typedef struct packed {
        pw_op_e   op;
        logic     acc;
        pw_base_t base;
        logic     abort;
    } row_t;

    logic                 clk;
    logic                 reset_n;
    logic                 zeroize;
    logic                 start;
    pw_op_e               op;
    logic                 accumulate;
    pw_base_t             base;
    mem_req_t             a_rd_req;
    mem_req_t             b_rd_req;
    mem_req_t             c_rd_req;
    mem_req_t             wr_req;
    logic [PW_WORD_W-1:0] a_rd_data;
    logic [PW_WORD_W-1:0] b_rd_data;
    logic [PW_WORD_W-1:0] c_rd_data;
    logic [PW_WORD_W-1:0] wr_data;
    logic                 busy;
    logic                 done;

    logic [PW_WORD_W-1:0] mem_a [PW_WORDS];
    logic [PW_WORD_W-1:0] mem_b [PW_WORDS];
    logic [PW_WORD_W-1:0] mem_c [PW_WORDS];
    logic [PW_WORD_W-1:0] exp_c [PW_WORDS];
    row_t                 rows [ROWS];
    int                   data_errs;
    int                   ctrl_errs;
    int                   cycle_cnt;

    pw_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .start_i      (start),
        .op_i         (op),
        .accumulate_i (accumulate),
        .base_i       (base),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .wr_req_o     (wr_req),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // A request has to fall in the 64 words above its base
    task automatic check_window(input string name, input logic [PW_ADDR_W-1:0] addr,
                                input logic [PW_ADDR_W-1:0] first);
        logic [PW_ADDR_W-1:0] offset;
        offset = addr - first;
        assert (offset < PW_ADDR_W'(PW_WORDS)) else begin
            $display("FAIL %s: got %h outside the window at %h", name, addr, first);
            ctrl_errs++;
        end
    endtask

    // ====================
    // Memory models
    // ====================
    // One cycle read latency and unknown data when no read was issued
    always @(posedge clk) begin
        if (a_rd_req.en) begin
            check_window("a_rd_req_o.addr", a_rd_req.addr, base.a_base);
        end
        if (b_rd_req.en) begin
            check_window("b_rd_req_o.addr", b_rd_req.addr, base.b_base);
        end
        if (c_rd_req.en) begin
            check_window("c_rd_req_o.addr", c_rd_req.addr, base.c_base);
        end
        a_rd_data <= a_rd_req.en ? mem_a[a_rd_req.addr[PW_IDX_W-1:0]] : 'x;
        b_rd_data <= b_rd_req.en ? mem_b[b_rd_req.addr[PW_IDX_W-1:0]] : 'x;
        c_rd_data <= c_rd_req.en ? mem_c[c_rd_req.addr[PW_IDX_W-1:0]] : 'x;
        if (wr_req.en) begin
            check_window("wr_req_o.addr", wr_req.addr, base.c_base);
            mem_c[wr_req.addr[PW_IDX_W-1:0]] = wr_data;
        end
    end

    // Modular result of one lane
    function automatic logic [PW_COEFF_W-1:0] ref_coeff(input pw_op_e o, input logic acc,
                                                        input longint unsigned a,
                                                        input longint unsigned b,
                                                        input longint unsigned c);
        longint unsigned q;
        longint unsigned r;
        q = 64'(PW_Q);
        case (o)
            PW_ADD:  r = (a + b) % q;
            PW_SUB:  r = (a + q - b) % q;
            default: r = acc ? ((a * b) % q + c) % q : (a * b) % q;
        endcase
        return PW_COEFF_W'(r);
    endfunction

    function automatic logic [PW_WORD_W-1:0] rand_word();
        logic [PW_WORD_W-1:0] w;
        w = '0;
        for (int l = 0; l < PW_LANES; l++) begin
            w[l*PW_LANE_W +: PW_COEFF_W] = PW_COEFF_W'($urandom % PW_Q);
        end
        return w;
    endfunction

    task automatic fill_memories(input row_t r);
        for (int k = 0; k < PW_WORDS; k++) begin
            mem_a[k] = rand_word();
            mem_b[k] = rand_word();
            if (r.acc) begin
                mem_c[k] = rand_word();
            end
        end
        // Edge pairs in lane 0 with q-1 twice, b above a and q-1 plus 1
        mem_a[0][PW_COEFF_W-1:0] = PW_Q - 1'b1;
        mem_b[0][PW_COEFF_W-1:0] = PW_Q - 1'b1;
        mem_a[1][PW_COEFF_W-1:0] = '0;
        mem_b[1][PW_COEFF_W-1:0] = PW_Q - 1'b1;
        mem_a[2][PW_COEFF_W-1:0] = PW_Q - 1'b1;
        mem_b[2][PW_COEFF_W-1:0] = 23'd1;
        if (r.acc) begin
            mem_c[0][PW_COEFF_W-1:0] = PW_Q - 1'b1;
        end
    endtask

    task automatic build_expected(input row_t r);
        int ia;
        int ib;
        int ic;
        exp_c = mem_c;
        for (int k = 0; k < PW_WORDS; k++) begin
            ia = (int'(r.base.a_base) + k) % PW_WORDS;
            ib = (int'(r.base.b_base) + k) % PW_WORDS;
            ic = (int'(r.base.c_base) + k) % PW_WORDS;
            for (int l = 0; l < PW_LANES; l++) begin
                exp_c[ic][l*PW_LANE_W +: PW_LANE_W] = {1'b0,
                    ref_coeff(r.op, r.acc, mem_a[ia][l*PW_LANE_W +: PW_COEFF_W],
                              mem_b[ib][l*PW_LANE_W +: PW_COEFF_W],
                              mem_c[ic][l*PW_LANE_W +: PW_COEFF_W])};
            end
        end
    endtask

    // Inputs change and outputs are sampled 5 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            ctrl_errs++;
        end
    endtask

    task automatic run_row(input row_t r);
        int cycles;
        fill_memories(r);
        build_expected(r);
        start      = 1'b1;
        op         = r.op;
        accumulate = r.acc;
        base       = r.base;
        next_cycle();
        start  = 1'b0;
        cycles = 1;
        if (r.abort) begin
            repeat (20) begin
                check_ctrl("busy_o", busy, 1'b1);
                next_cycle();
            end
            zeroize = 1'b1;
            next_cycle();
            zeroize = 1'b0;
            for (int i = 1; i <= RUN_CYCLES; i++) begin
                check_ctrl("busy_o", busy, 1'b0);
                check_ctrl("done_o", done, 1'b0);
                if (i >= 3) begin
                    check_ctrl("wr_req_o.en", wr_req.en, 1'b0);
                end
                next_cycle();
            end
        end else begin
            while (!done && cycles <= 2 * RUN_CYCLES) begin
                check_ctrl("busy_o", busy, 1'b1);
                next_cycle();
                cycles++;
            end
            if (!done) begin
                $display("done_o never pulsed after start of operation %0d", r.op);
                ctrl_errs++;
            end else begin
                assert (cycles == RUN_CYCLES) else begin
                    $display("FAIL done_o latency: got %h expected %h", cycles, RUN_CYCLES);
                    ctrl_errs++;
                end
                check_ctrl("busy_o", busy, 1'b0);
                next_cycle();
                check_ctrl("done_o", done, 1'b0);
                check_ctrl("busy_o", busy, 1'b0);
                for (int k = 0; k < PW_WORDS; k++) begin
                    assert (mem_c[k] === exp_c[k]) else begin
                        $display("FAIL mem_c[%0d]: got %h expected %h", k, mem_c[k], exp_c[k]);
                        data_errs++;
                    end
                end
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(SEED));
        data_errs  = 0;
        ctrl_errs  = 0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        start      = 1'b0;
        op         = PW_MUL;
        accumulate = 1'b0;
        base       = '0;
        // op, acc, {a_base, b_base, c_base}, abort
        rows[0] = '{PW_MUL, 1'b0, '{15'h0000, 15'h0040, 15'h0080}, 1'b0};
        rows[1] = '{PW_MUL, 1'b1, '{15'h0005, 15'h0105, 15'h0200}, 1'b0};
        rows[2] = '{PW_ADD, 1'b0, '{15'h0100, 15'h0000, 15'h0013}, 1'b0};
        rows[3] = '{PW_SUB, 1'b0, '{15'h0040, 15'h0080, 15'h0021}, 1'b0};
        rows[4] = '{PW_MUL, 1'b1, '{15'h0000, 15'h0000, 15'h0000}, 1'b1};
        rows[5] = '{PW_SUB, 1'b0, '{15'h0011, 15'h0023, 15'h0037}, 1'b0};
        rows[6] = '{PW_ADD, 1'b1, '{15'h0009, 15'h002e, 15'h7ff0}, 1'b0};
        rows[7] = '{PW_MUL, 1'b0, '{15'h003f, 15'h0001, 15'h0010}, 1'b0};
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset_n = 1'b1;
        next_cycle();
        for (int n = 0; n < ROWS; n++) begin
            run_row(rows[n]);
        end
        $display("Errors: data %0d, control %0d, assertions %0d",
                 data_errs, ctrl_errs, DUT.u_ctrl.u_assert.fail_cnt);
        if (data_errs + ctrl_errs + DUT.u_ctrl.u_assert.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/pw_tb_assert.sv */
// ====================
// Controller assertions
// Done width, reads only while busy, and no C read
// outside an accumulating multiply
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_tb_assert (
    input logic             clk,
    input logic             reset_n,
    input logic             zeroize_i,
    input logic             start_i,
    input pw_pkg::pw_op_e   op_i,
    input logic             accumulate_i,
    input logic             busy_i,
    input logic             done_i,
    input pw_pkg::mem_req_t a_rd_req_i,
    input pw_pkg::mem_req_t b_rd_req_i,
    input pw_pkg::mem_req_t c_rd_req_i
);
    import pw_pkg::*;

    int   fail_cnt = 0;
    logic mul_acc_q;

    // Command taken at the last accepted start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_acc_q <= 1'b0;
        end else if (start_i && !busy_i && !zeroize_i) begin
            mul_acc_q <= (op_i == PW_MUL) && accumulate_i;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            $error("done_o stayed high for more than one cycle");
            fail_cnt++;
        end

    read_only_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_i |-> !(a_rd_req_i.en || b_rd_req_i.en || c_rd_req_i.en))
        else begin
            $error("read request issued while not busy");
            fail_cnt++;
        end

    // C is only an addend of the multiply
    no_c_read_add_sub: assert property (@(posedge clk) disable iff (!reset_n)
        c_rd_req_i.en |-> mul_acc_q)
        else begin
            $error("C read enabled outside an accumulating multiply");
            fail_cnt++;
        end

endmodule

bind pw_ctrl pw_tb_assert u_assert (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize_i    (zeroize_i),
    .start_i      (start_i),
    .op_i         (op_i),
    .accumulate_i (accumulate_i),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .a_rd_req_i   (a_rd_req_o),
    .b_rd_req_i   (b_rd_req_o),
    .c_rd_req_i   (c_rd_req_o)
);

`default_nettype wire

/* design/pw_top.sv */
// ====================
// Pointwise engine top
// Controller, operand stage and ALU in a three-deep
// pipeline behind external A, B and C memories
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  logic                          start_i,
    input  pw_pkg::pw_op_e                op_i,
    input  logic                          accumulate_i,
    input  pw_pkg::pw_base_t              base_i,
    output pw_pkg::mem_req_t              a_rd_req_o,
    output pw_pkg::mem_req_t              b_rd_req_o,
    output pw_pkg::mem_req_t              c_rd_req_o,
    input  logic [pw_pkg::PW_WORD_W-1:0]  a_rd_data_i,
    input  logic [pw_pkg::PW_WORD_W-1:0]  b_rd_data_i,
    input  logic [pw_pkg::PW_WORD_W-1:0]  c_rd_data_i,
    output pw_pkg::mem_req_t              wr_req_o,
    output logic [pw_pkg::PW_WORD_W-1:0]  wr_data_o,
    output logic                          busy_o,
    output logic                          done_o
);
    import pw_pkg::*;

    logic                 rd_strobe;
    logic [PW_IDX_W-1:0]  rd_idx;
    pw_op_e               op_lat;
    logic [PW_ADDR_W-1:0] c_base;
    pw_operands_t         ops;
    logic                 last_wr;

    pw_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .op_i         (op_i),
        .accumulate_i (accumulate_i),
        .base_i       (base_i),
        .last_wr_i    (last_wr),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .rd_strobe_o  (rd_strobe),
        .rd_idx_o     (rd_idx),
        .op_o         (op_lat),
        .c_base_o     (c_base),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    pw_operand_stage u_operand_stage (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .rd_strobe_i (rd_strobe),
        .rd_idx_i    (rd_idx),
        .c_rd_en_i   (c_rd_req_o.en),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .ops_o       (ops)
    );

    pw_alu u_alu (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .ops_i     (ops),
        .op_i      (op_lat),
        .c_base_i  (c_base),
        .wr_req_o  (wr_req_o),
        .wr_data_o (wr_data_o),
        .last_wr_o (last_wr)
    );

endmodule

`default_nettype wire

/* design/pw_alu.sv */
// ====================
// Pointwise ALU
// Four lanes of modular multiply-accumulate, add and
// subtract mod q, packed into one registered C write
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_alu (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  pw_pkg::pw_operands_t          ops_i,
    input  pw_pkg::pw_op_e                op_i,
    input  logic [pw_pkg::PW_ADDR_W-1:0]  c_base_i,
    output pw_pkg::mem_req_t              wr_req_o,
    output logic [pw_pkg::PW_WORD_W-1:0]  wr_data_o,
    output logic                          last_wr_o
);
    import pw_pkg::*;

    logic [PW_LANES-1:0][2*PW_COEFF_W-1:0] prod;
    pw_lanes_t                              res;
    logic [PW_WORD_W-1:0]                   wr_word;
    logic                                   wr_en_q;
    logic [PW_ADDR_W-1:0]                   wr_addr_q;
    logic                                   last_q;
    logic [PW_WORD_W-1:0]                   wr_data_q;

    // 2^23 == 2^13 - 1 mod q, so the upper part folds down three times
    function automatic logic [PW_COEFF_W-1:0] reduce_q(input logic [2*PW_COEFF_W-1:0] x);
        logic [37:0] s1;
        logic [28:0] s2;
        logic [24:0] s3;
        s1 = x[22:0] + {x[45:23], 13'd0} - x[45:23];
        s2 = s1[22:0] + {s1[37:23], 13'd0} - s1[37:23];
        s3 = s2[22:0] + {s2[28:23], 13'd0} - s2[28:23];
        // Now below 2q
        if (s3 >= 25'(PW_Q)) begin
            s3 = s3 - 25'(PW_Q);
        end
        return s3[PW_COEFF_W-1:0];
    endfunction

    // Both inputs at most q, so one correction is enough
    function automatic logic [PW_COEFF_W-1:0] add_q(input logic [PW_COEFF_W-1:0] a,
                                                    input logic [PW_COEFF_W-1:0] b);
        logic [PW_COEFF_W:0] s;
        s = a + b;
        if (s >= {1'b0, PW_Q}) begin
            s = s - {1'b0, PW_Q};
        end
        return s[PW_COEFF_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < PW_LANES; i++) begin
            prod[i] = ops_i.u[i] * ops_i.v[i];
            case (op_i)
                PW_ADD:  res[i] = add_q(ops_i.u[i], ops_i.v[i]);
                PW_SUB:  res[i] = add_q(ops_i.u[i], PW_Q - ops_i.v[i]);
                // w is zero when not accumulating
                default: res[i] = add_q(reduce_q(prod[i]), ops_i.w[i]);
            endcase
            wr_word[i*PW_LANE_W +: PW_LANE_W] = {{(PW_LANE_W-PW_COEFF_W){1'b0}}, res[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_q   <= 1'b0;
            wr_addr_q <= '0;
            last_q    <= 1'b0;
        end else if (zeroize_i) begin
            wr_en_q   <= 1'b0;
            wr_addr_q <= '0;
            last_q    <= 1'b0;
        end else begin
            wr_en_q   <= ops_i.valid;
            wr_addr_q <= c_base_i + PW_ADDR_W'(ops_i.idx);
            last_q    <= ops_i.valid && (ops_i.idx == PW_IDX_W'(PW_WORDS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            wr_data_q <= '0;
        end else if (ops_i.valid) begin
            wr_data_q <= wr_word;
        end
    end

    assign wr_req_o.en   = wr_en_q;
    assign wr_req_o.addr = wr_addr_q;
    assign wr_data_o     = wr_data_q;
    assign last_wr_o     = last_q;

endmodule

`default_nettype wire

/* design/pw_operand_stage.sv */
// ====================
// Operand stage
// Lines up the read strobe with the memory latency and
// registers A, B and C words as 23-bit coefficient lanes
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_operand_stage (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  logic                          rd_strobe_i,
    input  logic [pw_pkg::PW_IDX_W-1:0]   rd_idx_i,
    input  logic                          c_rd_en_i,
    input  logic [pw_pkg::PW_WORD_W-1:0]  a_rd_data_i,
    input  logic [pw_pkg::PW_WORD_W-1:0]  b_rd_data_i,
    input  logic [pw_pkg::PW_WORD_W-1:0]  c_rd_data_i,
    output pw_pkg::pw_operands_t          ops_o
);
    import pw_pkg::*;

    logic                strobe_d;
    logic                c_en_d;
    logic [PW_IDX_W-1:0] idx_d;
    logic                valid_q;
    logic [PW_IDX_W-1:0] idx_q;
    pw_lanes_t           u_q;
    pw_lanes_t           v_q;
    pw_lanes_t           w_q;

    // Drop the pad bit of every lane
    function automatic pw_lanes_t unpack(input logic [PW_WORD_W-1:0] word);
        pw_lanes_t lanes;
        for (int i = 0; i < PW_LANES; i++) begin
            lanes[i] = word[i*PW_LANE_W +: PW_COEFF_W];
        end
        return lanes;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            strobe_d <= 1'b0;
            c_en_d   <= 1'b0;
            idx_d    <= '0;
            valid_q  <= 1'b0;
            idx_q    <= '0;
        end else if (zeroize_i) begin
            strobe_d <= 1'b0;
            c_en_d   <= 1'b0;
            idx_d    <= '0;
            valid_q  <= 1'b0;
            idx_q    <= '0;
        end else begin
            // First stage tracks the cycle the memory answers in
            strobe_d <= rd_strobe_i;
            c_en_d   <= c_rd_en_i;
            idx_d    <= rd_idx_i;
            valid_q  <= strobe_d;
            idx_q    <= idx_d;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            u_q <= '0;
            v_q <= '0;
            w_q <= '0;
        end else if (strobe_d) begin
            u_q <= unpack(a_rd_data_i);
            v_q <= unpack(b_rd_data_i);
            // C holds nothing valid unless it was read
            w_q <= c_en_d ? unpack(c_rd_data_i) : '0;
        end
    end

    always_comb begin
        ops_o.u     = u_q;
        ops_o.v     = v_q;
        ops_o.w     = w_q;
        ops_o.valid = valid_q;
        ops_o.idx   = idx_q;
    end

endmodule

`default_nettype wire

/* design/pw_ctrl.sv */
// ====================
// Pointwise controller
// Latches the command on start, walks the 64 word indices
// and issues the A, B and optional C read requests.
// Holds busy until the ALU reports its last write
// ====================
`timescale 1ns/1ps
`default_nettype none

module pw_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  logic                          start_i,
    input  pw_pkg::pw_op_e                op_i,
    input  logic                          accumulate_i,
    input  pw_pkg::pw_base_t              base_i,
    input  logic                          last_wr_i,
    output pw_pkg::mem_req_t              a_rd_req_o,
    output pw_pkg::mem_req_t              b_rd_req_o,
    output pw_pkg::mem_req_t              c_rd_req_o,
    output logic                          rd_strobe_o,
    output logic [pw_pkg::PW_IDX_W-1:0]   rd_idx_o,
    output pw_pkg::pw_op_e                op_o,
    output logic [pw_pkg::PW_ADDR_W-1:0]  c_base_o,
    output logic                          busy_o,
    output logic                          done_o
);
    import pw_pkg::*;

    logic                busy_q;
    logic                rd_active_q;
    logic                done_q;
    logic [PW_IDX_W-1:0] cnt_q;
    pw_op_e              op_q;
    logic                acc_q;
    pw_base_t            base_q;
    logic                c_rd_en;

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q      <= 1'b0;
            rd_active_q <= 1'b0;
            done_q      <= 1'b0;
            cnt_q       <= '0;
            op_q        <= PW_MUL;
            acc_q       <= 1'b0;
            base_q      <= '0;
        end else if (zeroize_i) begin
            busy_q      <= 1'b0;
            rd_active_q <= 1'b0;
            done_q      <= 1'b0;
            cnt_q       <= '0;
            op_q        <= PW_MUL;
            acc_q       <= 1'b0;
            base_q      <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q      <= 1'b1;
                rd_active_q <= 1'b1;
                cnt_q       <= '0;
                op_q        <= op_i;
                acc_q       <= accumulate_i;
                base_q      <= base_i;
            end else begin
                // One read per cycle until index 63 is out
                if (rd_active_q) begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == PW_IDX_W'(PW_WORDS - 1)) begin
                        rd_active_q <= 1'b0;
                    end
                end
                if (busy_q && last_wr_i) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Only an accumulating multiply needs the old C contents
    assign c_rd_en = (op_q == PW_MUL) && acc_q;

    always_comb begin
        a_rd_req_o.en   = rd_active_q;
        a_rd_req_o.addr = base_q.a_base + PW_ADDR_W'(cnt_q);
        b_rd_req_o.en   = rd_active_q;
        b_rd_req_o.addr = base_q.b_base + PW_ADDR_W'(cnt_q);
        c_rd_req_o.en   = rd_active_q && c_rd_en;
        c_rd_req_o.addr = c_rd_en ? base_q.c_base + PW_ADDR_W'(cnt_q) : '0;
    end

    assign rd_strobe_o = rd_active_q;
    assign rd_idx_o    = cnt_q;
    assign op_o        = op_q;
    assign c_base_o    = base_q.c_base;
    assign busy_o      = busy_q;
    assign done_o      = done_q;

endmodule

`default_nettype wire

/* design/pw_pkg.sv */
// ====================
// Pointwise engine shared definitions
// Modulus, field widths, operation encoding and the
// structs carried between controller, operand stage and ALU
// ====================
`default_nettype none

package pw_pkg;

    // ====================
    // Field constants
    // ====================
    localparam int unsigned PW_COEFF_W = 23;
    localparam int unsigned PW_LANE_W  = 24;
    localparam int unsigned PW_LANES   = 4;
    localparam int unsigned PW_WORD_W  = PW_LANES * PW_LANE_W;
    localparam int unsigned PW_ADDR_W  = 15;
    localparam int unsigned PW_WORDS   = 64;
    localparam int unsigned PW_IDX_W   = $clog2(PW_WORDS);

    // ML-DSA modulus, 2^23 - 2^13 + 1
    localparam logic [PW_COEFF_W-1:0] PW_Q = 23'd8380417;

    // ====================
    // Operations and buses
    // ====================
    typedef enum logic [1:0] {
        PW_MUL = 2'b00,
        PW_ADD = 2'b01,
        PW_SUB = 2'b10
    } pw_op_e;

    typedef struct packed {
        logic                 en;
        logic [PW_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [PW_ADDR_W-1:0] a_base;
        logic [PW_ADDR_W-1:0] b_base;
        logic [PW_ADDR_W-1:0] c_base;
    } pw_base_t;

    // Lane 0 sits in the low bits of a memory word
    typedef logic [PW_LANES-1:0][PW_COEFF_W-1:0] pw_lanes_t;

    typedef struct packed {
        pw_lanes_t           u;
        pw_lanes_t           v;
        pw_lanes_t           w;
        logic                valid;
        logic [PW_IDX_W-1:0] idx;
    } pw_operands_t;

endpackage

`default_nettype wire
